//--- source/isa_pkg.sv
package isa_pkg;

	localparam int INSTR_W    = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 16;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;

	// low bit of each instruction field
	localparam int OPCODE_LO = 26;
	localparam int RS_LO     = 21;
	localparam int RT_LO     = 16;
	localparam int RD_LO     = 11;
	localparam int FUNCT_LO  = 0;

	typedef enum logic [OPCODE_W-1:0] {
		OP_RTYPE = 6'b000000,
		OP_ADDI  = 6'b001000,
		OP_SLTI  = 6'b001010,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001111,
		OP_ANDI  = 6'b000001, // not the usual mips code
		OP_LUI   = 6'b000111
	} opcode_e;

	typedef enum logic [FUNCT_W-1:0] {
		F_ADD  = 6'h20,
		F_SUB  = 6'h22,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2A,
		F_SLLV = 6'h04,
		F_SRLV = 6'h06,
		F_SRAV = 6'h07
	} funct_e;

endpackage

//--- source/core_pkg.sv
package core_pkg;

	localparam int XLEN     = 32;
	localparam int NUM_REGS = 32;
	localparam int SHAMT_W  = $clog2(XLEN); // shift amount bits taken from operand b

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B
	} alu_op_e;

	// cause codes as carried in the cause register field
	typedef enum logic [4:0] {
		EXC_NONE     = 5'b00000,
		EXC_UNKNOWN  = 5'b00010,
		EXC_OVERFLOW = 5'b00100
	} exc_cause_e;

	localparam logic [XLEN-1:0] VEC_UNKNOWN  = 32'h0000_0150;
	localparam logic [XLEN-1:0] VEC_OVERFLOW = 32'h0000_0064;

endpackage

//--- source/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_pkg::*, isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	input  logic                  wb_en,
	input  logic [REG_ADDR_W-1:0] wb_reg,
	input  logic [XLEN-1:0]       wb_data,
	output logic [XLEN-1:0]       rs_data,
	output logic [XLEN-1:0]       rt_data
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// async reads, r0 hardwired to zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import core_pkg::*, isa_pkg::*; (
	input  logic                  instr_valid,
	input  logic [INSTR_W-1:0]    instr,
	input  logic [XLEN-1:0]       rs_data,
	input  logic [XLEN-1:0]       rt_data,
	input  logic                  wb_en,
	input  logic [REG_ADDR_W-1:0] wb_reg,
	input  logic [XLEN-1:0]       wb_data,
	output logic [REG_ADDR_W-1:0] rs_addr,
	output logic [REG_ADDR_W-1:0] rt_addr,
	output logic                  d_valid,
	output alu_op_e               alu_op,
	output logic [XLEN-1:0]       opa,
	output logic [XLEN-1:0]       opb,
	output logic [REG_ADDR_W-1:0] dest_reg,
	output logic                  writes_reg,
	output logic                  unknown
);

	opcode_e               opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic [IMM_W-1:0]      imm;
	logic [XLEN-1:0]       imm_sext;
	logic [XLEN-1:0]       imm_zext;
	logic [XLEN-1:0]       rs_val;
	logic [XLEN-1:0]       rt_val;

	assign opcode  = opcode_e'(instr[OPCODE_LO +: OPCODE_W]);
	assign funct   = funct_e'(instr[FUNCT_LO +: FUNCT_W]);
	assign rs_addr = instr[RS_LO +: REG_ADDR_W];
	assign rt_addr = instr[RT_LO +: REG_ADDR_W];
	assign rd_addr = instr[RD_LO +: REG_ADDR_W];
	assign imm     = instr[IMM_W-1:0];

	assign imm_sext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
	assign imm_zext = {{(XLEN-IMM_W){1'b0}}, imm};

	// bypass from the instruction now in execute
	assign rs_val = (wb_en && wb_reg == rs_addr) ? wb_data : rs_data;
	assign rt_val = (wb_en && wb_reg == rt_addr) ? wb_data : rt_data;

	assign d_valid = instr_valid;

	always_comb begin
		alu_op   = ALU_ADD;
		opa      = rs_val;
		opb      = rt_val;
		dest_reg = rt_addr; // immediate forms write rt
		unknown  = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				dest_reg = rd_addr;
				case (funct)
					F_ADD:   alu_op = ALU_ADD;
					F_SUB:   alu_op = ALU_SUB;
					F_AND:   alu_op = ALU_AND;
					F_OR:    alu_op = ALU_OR;
					F_XOR:   alu_op = ALU_XOR;
					F_NOR:   alu_op = ALU_NOR;
					F_SLT:   alu_op = ALU_SLT;
					F_SLLV:  alu_op = ALU_SLL;
					F_SRLV:  alu_op = ALU_SRL;
					F_SRAV:  alu_op = ALU_SRA;
					default: unknown = 1'b1;
				endcase
			end
			OP_ADDI: begin
				alu_op = ALU_ADD;
				opb    = imm_sext;
			end
			OP_SLTI: begin
				alu_op = ALU_SLT;
				opb    = imm_sext;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				opb    = imm_zext;
			end
			OP_XORI: begin
				alu_op = ALU_XOR;
				opb    = imm_zext;
			end
			OP_ANDI: begin
				alu_op = ALU_AND;
				opb    = imm_zext;
			end
			OP_LUI: begin
				alu_op = ALU_PASS_B;
				opb    = {imm, {(XLEN-IMM_W){1'b0}}}; // immediate in upper half
			end
			default: unknown = 1'b1;
		endcase
	end

	assign writes_reg = !unknown && (dest_reg != '0);

endmodule

//--- source/exec_latch.sv
`timescale 1ns/100ps

module exec_latch import core_pkg::*, isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  d_valid,
	input  alu_op_e               alu_op,
	input  logic [XLEN-1:0]       opa,
	input  logic [XLEN-1:0]       opb,
	input  logic [REG_ADDR_W-1:0] dest_reg,
	input  logic                  writes_reg,
	input  logic                  unknown,
	output logic                  e_valid,
	output alu_op_e               e_alu_op,
	output logic [XLEN-1:0]       e_opa,
	output logic [XLEN-1:0]       e_opb,
	output logic [REG_ADDR_W-1:0] e_dest_reg,
	output logic                  e_writes_reg,
	output logic                  e_unknown
);

	// a flush kills the instruction coming out of decode
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			e_valid      <= 1'b0;
			e_writes_reg <= 1'b0;
			e_unknown    <= 1'b0;
		end else begin
			e_valid      <= d_valid;
			e_writes_reg <= writes_reg;
			e_unknown    <= unknown;
		end
	end

	always_ff @(posedge clk) begin
		e_alu_op   <= alu_op;
		e_opa      <= opa;
		e_opb      <= opb;
		e_dest_reg <= dest_reg;
	end

endmodule

//--- source/alu.sv
`timescale 1ns/100ps

module alu import core_pkg::*; (
	input  alu_op_e         alu_op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] y,
	output logic            overflow
);

	logic [XLEN:0]      sum;
	logic [XLEN:0]      diff;
	logic [SHAMT_W-1:0] shamt;

	// one extra bit catches the unsigned carry / borrow
	assign sum   = {1'b0, a} + {1'b0, b};
	assign diff  = {1'b0, a} - {1'b0, b};
	assign shamt = b[SHAMT_W-1:0];

	always_comb begin
		y        = '0;
		overflow = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				y        = sum[XLEN-1:0];
				overflow = sum[XLEN];
			end
			ALU_SUB: begin
				y        = diff[XLEN-1:0];
				overflow = diff[XLEN]; // borrow
			end
			ALU_AND:    y = a & b;
			ALU_OR:     y = a | b;
			ALU_XOR:    y = a ^ b;
			ALU_NOR:    y = ~(a | b);
			ALU_SLT:    y = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
			ALU_SLL:    y = a << shamt;
			ALU_SRL:    y = a >> shamt;
			ALU_SRA:    y = $unsigned($signed(a) >>> shamt);
			ALU_PASS_B: y = b;
			default:    y = '0;
		endcase
	end

endmodule

//--- source/exec_stage.sv
`timescale 1ns/100ps

module exec_stage import core_pkg::*, isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  e_valid,
	input  alu_op_e               e_alu_op,
	input  logic [XLEN-1:0]       e_opa,
	input  logic [XLEN-1:0]       e_opb,
	input  logic [REG_ADDR_W-1:0] e_dest_reg,
	input  logic                  e_writes_reg,
	input  logic                  e_unknown,
	output logic                  wb_en,
	output logic [REG_ADDR_W-1:0] wb_reg,
	output logic [XLEN-1:0]       wb_data,
	output logic                  flush,
	output logic                  result_valid,
	output logic [XLEN-1:0]       result_data,
	output logic [REG_ADDR_W-1:0] result_reg,
	output logic                  exc_valid,
	output exc_cause_e            exc_cause,
	output logic [XLEN-1:0]       exc_vector
);

	logic [XLEN-1:0] alu_y;
	logic            alu_ovf;
	exc_cause_e      cause;
	logic [XLEN-1:0] vector;

	alu u_alu (
		.alu_op   (e_alu_op),
		.a        (e_opa),
		.b        (e_opb),
		.y        (alu_y),
		.overflow (alu_ovf)
	);

	// unknown wins over overflow
	always_comb begin
		if (e_unknown)
			cause = EXC_UNKNOWN;
		else if (alu_ovf)
			cause = EXC_OVERFLOW;
		else
			cause = EXC_NONE;
	end

	always_comb begin
		case (cause)
			EXC_UNKNOWN:  vector = VEC_UNKNOWN;
			EXC_OVERFLOW: vector = VEC_OVERFLOW;
			default:      vector = '0;
		endcase
	end

	assign flush   = e_valid && (cause != EXC_NONE);
	assign wb_en   = e_valid && e_writes_reg && (cause == EXC_NONE); // written at end of this cycle
	assign wb_reg  = e_dest_reg;
	assign wb_data = alu_y;

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			exc_valid    <= 1'b0;
		end else begin
			result_valid <= e_valid && (cause == EXC_NONE);
			exc_valid    <= flush;
		end
	end

	always_ff @(posedge clk) begin
		result_data <= alu_y;
		result_reg  <= e_dest_reg; // reported even for r0
		exc_cause   <= cause;
		exc_vector  <= vector;
	end

endmodule

//--- source/alu_core_top.sv
`timescale 1ns/100ps

module alu_core_top import core_pkg::*, isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  instr_valid,
	input  logic [INSTR_W-1:0]    instr,
	output logic                  result_valid,
	output logic [XLEN-1:0]       result_data,
	output logic [REG_ADDR_W-1:0] result_reg,
	output logic                  exc_valid,
	output exc_cause_e            exc_cause,
	output logic [XLEN-1:0]       exc_vector
);

	logic [REG_ADDR_W-1:0] rs_addr;
	logic [REG_ADDR_W-1:0] rt_addr;
	logic [XLEN-1:0]       rs_data;
	logic [XLEN-1:0]       rt_data;

	// decode side bundle
	logic                  d_valid;
	alu_op_e               alu_op;
	logic [XLEN-1:0]       opa;
	logic [XLEN-1:0]       opb;
	logic [REG_ADDR_W-1:0] dest_reg;
	logic                  writes_reg;
	logic                  unknown;

	// execute side bundle
	logic                  e_valid;
	alu_op_e               e_alu_op;
	logic [XLEN-1:0]       e_opa;
	logic [XLEN-1:0]       e_opb;
	logic [REG_ADDR_W-1:0] e_dest_reg;
	logic                  e_writes_reg;
	logic                  e_unknown;

	logic                  wb_en;
	logic [REG_ADDR_W-1:0] wb_reg;
	logic [XLEN-1:0]       wb_data;
	logic                  flush;

	decode_stage u_decode (
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.wb_en       (wb_en),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.d_valid     (d_valid),
		.alu_op      (alu_op),
		.opa         (opa),
		.opb         (opb),
		.dest_reg    (dest_reg),
		.writes_reg  (writes_reg),
		.unknown     (unknown)
	);

	exec_latch u_latch (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.d_valid      (d_valid),
		.alu_op       (alu_op),
		.opa          (opa),
		.opb          (opb),
		.dest_reg     (dest_reg),
		.writes_reg   (writes_reg),
		.unknown      (unknown),
		.e_valid      (e_valid),
		.e_alu_op     (e_alu_op),
		.e_opa        (e_opa),
		.e_opb        (e_opb),
		.e_dest_reg   (e_dest_reg),
		.e_writes_reg (e_writes_reg),
		.e_unknown    (e_unknown)
	);

	exec_stage u_exec (
		.clk          (clk),
		.rst          (rst),
		.e_valid      (e_valid),
		.e_alu_op     (e_alu_op),
		.e_opa        (e_opa),
		.e_opb        (e_opb),
		.e_dest_reg   (e_dest_reg),
		.e_writes_reg (e_writes_reg),
		.e_unknown    (e_unknown),
		.wb_en        (wb_en),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.flush        (flush),
		.result_valid (result_valid),
		.result_data  (result_data),
		.result_reg   (result_reg),
		.exc_valid    (exc_valid),
		.exc_cause    (exc_cause),
		.exc_vector   (exc_vector)
	);

	reg_file u_regs (
		.clk     (clk),
		.rst     (rst),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.wb_en   (wb_en),
		.wb_reg  (wb_reg),
		.wb_data (wb_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

endmodule

//--- verification/alu_core_chk.sv
`timescale 1ns/100ps

module alu_core_chk import core_pkg::*; (
	input logic            clk,
	input logic            rst,
	input logic            instr_valid,
	input logic            result_valid,
	input logic            exc_valid,
	input exc_cause_e      exc_cause,
	input logic [XLEN-1:0] exc_vector
);

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		!(result_valid && exc_valid))
		else $error("result and exception strobes high in the same cycle");

	a_ovf_vector: assert property (@(posedge clk) disable iff (rst)
		(exc_valid && exc_cause == EXC_OVERFLOW) |-> exc_vector == 32'h0000_0064)
		else $error("overflow exception with wrong handler vector");

	// answer two cycles on, unless the older instruction flushed this one
	a_answer: assert property (@(posedge clk) disable iff (rst)
		instr_valid |=> (exc_valid or (##1 (result_valid || exc_valid))))
		else $error("instruction issued without any output");

endmodule

bind alu_core_top alu_core_chk chk_i (
	.clk          (clk),
	.rst          (rst),
	.instr_valid  (instr_valid),
	.result_valid (result_valid),
	.exc_valid    (exc_valid),
	.exc_cause    (exc_cause),
	.exc_vector   (exc_vector)
);

//--- verification/alu_core_tb.sv
`timescale 1ns/100ps

module alu_core_tb import core_pkg::*, isa_pkg::*; ();

	localparam int K_RES  = 0;
	localparam int K_OVF  = 1;
	localparam int K_UNK  = 2;
	localparam int K_DROP = 3; // flushed with no output at all

	logic                  clk;
	logic                  rst;
	logic                  instr_valid;
	logic [INSTR_W-1:0]    instr;
	logic                  result_valid;
	logic [XLEN-1:0]       result_data;
	logic [REG_ADDR_W-1:0] result_reg;
	logic                  exc_valid;
	exc_cause_e            exc_cause;
	logic [XLEN-1:0]       exc_vector;

	logic [31:0] tbl_instr[$];
	bit          tbl_gap[$]; // idle cycle before issue
	int          tbl_kind[$];
	logic [4:0]  tbl_reg[$];
	logic [31:0] tbl_val[$]; // result data or handler vector

	int pend_idx[$];
	int pend_due[$];
	int issued;
	int errors;

	alu_core_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.result_valid (result_valid),
		.result_data  (result_data),
		.result_reg   (result_reg),
		.exc_valid    (exc_valid),
		.exc_cause    (exc_cause),
		.exc_vector   (exc_vector)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] encode_r(input logic [5:0] f, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_row(input logic [31:0] ins, input bit gap, input int kind,
			input logic [4:0] dest, input logic [31:0] val);
		tbl_instr.push_back(ins);
		tbl_gap.push_back(gap);
		tbl_kind.push_back(kind);
		tbl_reg.push_back(dest);
		tbl_val.push_back(val);
	endtask

	task automatic build_table();
		add_row(encode_i(OP_ADDI, 0, 1, 16'h0005), 1, K_RES, 1, 32'h0000_0005);
		add_row(encode_i(OP_ADDI, 0, 2, 16'hFFFD), 1, K_RES, 2, 32'hFFFF_FFFD); // sign ext
		add_row(encode_i(OP_ORI, 0, 3, 16'h8001), 1, K_RES, 3, 32'h0000_8001); // zero ext
		add_row(encode_i(OP_LUI, 0, 4, 16'h8000), 1, K_RES, 4, 32'h8000_0000);
		add_row(encode_i(OP_ANDI, 3, 5, 16'h00FF), 1, K_RES, 5, 32'h0000_0001);
		add_row(encode_i(OP_XORI, 3, 6, 16'hFFFF), 1, K_RES, 6, 32'h0000_7FFE);
		add_row(encode_i(OP_ADDI, 0, 7, 16'h0004), 0, K_RES, 7, 32'h0000_0004);
		add_row(encode_r(F_ADD, 1, 7, 8), 0, K_RES, 8, 32'h0000_0009); // r7 bypassed
		add_row(encode_r(F_SUB, 1, 7, 9), 0, K_RES, 9, 32'h0000_0001);
		add_row(encode_r(F_AND, 2, 3, 10), 0, K_RES, 10, 32'h0000_8001);
		add_row(encode_r(F_OR, 1, 4, 11), 0, K_RES, 11, 32'h8000_0005);
		add_row(encode_r(F_XOR, 2, 1, 12), 0, K_RES, 12, 32'hFFFF_FFF8);
		add_row(encode_r(F_NOR, 1, 7, 13), 0, K_RES, 13, 32'hFFFF_FFFA);
		add_row(encode_r(F_SLT, 2, 1, 14), 0, K_RES, 14, 32'h0000_0001); // -3 < 5
		add_row(encode_r(F_SLLV, 1, 7, 16), 0, K_RES, 16, 32'h0000_0050);
		add_row(encode_r(F_SRLV, 4, 7, 17), 0, K_RES, 17, 32'h0800_0000);
		add_row(encode_r(F_SRAV, 4, 7, 18), 0, K_RES, 18, 32'hF800_0000);
		// dependent chain issued one per cycle
		add_row(encode_i(OP_ADDI, 0, 20, 16'h0010), 1, K_RES, 20, 32'h0000_0010);
		add_row(encode_r(F_ADD, 20, 20, 20), 0, K_RES, 20, 32'h0000_0020);
		add_row(encode_r(F_ADD, 20, 1, 21), 0, K_RES, 21, 32'h0000_0025);
		add_row(encode_i(OP_SLTI, 2, 22, 16'hFFFF), 0, K_RES, 22, 32'h0000_0001);
		// carry and borrow leave their destinations untouched
		add_row(encode_r(F_ADD, 4, 2, 23), 1, K_OVF, 0, 32'h0000_0064);
		add_row(encode_r(F_ADD, 23, 0, 24), 1, K_RES, 24, 32'h0000_0000);
		add_row(encode_r(F_SUB, 7, 1, 1), 1, K_OVF, 0, 32'h0000_0064);
		add_row(encode_r(F_OR, 1, 0, 25), 1, K_RES, 25, 32'h0000_0005);
		// unknown opcode then unknown funct each flush the next one
		add_row(encode_i(6'h3F, 0, 26, 16'h0000), 1, K_UNK, 0, 32'h0000_0150);
		add_row(encode_i(OP_ADDI, 0, 1, 16'h0777), 0, K_DROP, 0, 32'h0);
		add_row(encode_r(F_OR, 1, 0, 26), 1, K_RES, 26, 32'h0000_0005);
		add_row(encode_r(6'h3F, 1, 1, 27), 1, K_UNK, 0, 32'h0000_0150);
		add_row(encode_i(OP_ADDI, 0, 7, 16'h0123), 0, K_DROP, 0, 32'h0);
		add_row(encode_r(F_ADD, 7, 0, 28), 1, K_RES, 28, 32'h0000_0004);
		add_row(encode_i(OP_ADDI, 0, 0, 16'h1234), 1, K_RES, 0, 32'h0000_1234);
		add_row(encode_r(F_OR, 0, 0, 29), 0, K_RES, 29, 32'h0000_0000); // r0 not bypassed
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_entry(input int idx);
		case (tbl_kind[idx])
			K_RES: begin
				assert (result_valid === 1'b1 && exc_valid === 1'b0) else begin
					errors++;
					$display("t=%0t entry %0d gave no result strobe", $time, idx);
				end
				if (result_valid === 1'b1) begin
					compare("result_data", result_data, tbl_val[idx]);
					compare("result_reg", result_reg, tbl_reg[idx]);
				end
			end
			K_OVF, K_UNK: begin
				assert (exc_valid === 1'b1 && result_valid === 1'b0) else begin
					errors++;
					$display("t=%0t entry %0d gave no exception strobe", $time, idx);
				end
				if (exc_valid === 1'b1) begin
					compare("exc_cause", exc_cause,
						(tbl_kind[idx] == K_OVF) ? EXC_OVERFLOW : EXC_UNKNOWN);
					compare("exc_vector", exc_vector, tbl_val[idx]);
				end
			end
			default: begin
				assert (result_valid === 1'b0 && exc_valid === 1'b0) else begin
					errors++;
					$display("t=%0t flushed entry %0d still produced output", $time, idx);
				end
			end
		endcase
	endtask

	// sample at the falling edge away from the driving edge
	initial begin : monitor
		int now_cyc;
		int idx;
		now_cyc = 0;
		forever begin
			@(negedge clk);
			now_cyc++;
			if (instr_valid === 1'b1) begin
				pend_idx.push_back(issued);
				pend_due.push_back(now_cyc + 2);
				issued++;
			end
			if (pend_due.size() > 0 && pend_due[0] == now_cyc) begin
				idx = pend_idx.pop_front();
				void'(pend_due.pop_front());
				check_entry(idx);
			end else begin
				assert (result_valid === 1'b0 && exc_valid === 1'b0) else begin
					errors++;
					$display("t=%0t output strobe with no instruction due", $time);
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		int limit;
		cycles = 0;
		@(posedge clk);
		limit = 4 * tbl_instr.size() + 20;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("timeout after %0d cycles, outputs never drained", cycles);
		$display("errors: %0d", errors);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		issued      = 0;
		errors      = 0;
		build_table();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		foreach (tbl_instr[i]) begin
			if (tbl_gap[i]) begin
				@(posedge clk);
				instr_valid <= 1'b0;
				instr       <= '0;
			end
			@(posedge clk);
			instr_valid <= 1'b1;
			instr       <= tbl_instr[i];
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		instr       <= '0;
		while (issued < tbl_instr.size() || pend_due.size() > 0)
			@(negedge clk);
		repeat (3) @(negedge clk); // catch stray strobes
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- flist.f
source/isa_pkg.sv
source/core_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/exec_latch.sv
source/alu.sv
source/exec_stage.sv
source/alu_core_top.sv
verification/alu_core_chk.sv
verification/alu_core_tb.sv
